// File: logic/vadd_macros.svh
`ifndef VADD_MACROS_SVH
`define VADD_MACROS_SVH

// Element and vector sizes
`define VADD_DATA_WIDTH 16
`define VADD_VECTOR_LENGTH 8        // Also depth of every FIFO
`define VADD_COUNT_WIDTH 4          // Holds 0..VADD_VECTOR_LENGTH

// Bus word
`define VADD_WB_WIDTH 32

// Word addresses, decoded from adr[3:2]
`define VADD_ADR_CTRL 2'd0
`define VADD_ADR_OPERAND 2'd1
`define VADD_ADR_RESULT 2'd2

`endif

// File: logic/vadd_core_pkg.sv
`include "vadd_macros.svh"

package vadd_core_pkg;

  // One vector element, sums wrap modulo 2^16
  typedef logic [`VADD_DATA_WIDTH-1:0] elem_t;

  typedef enum logic [1:0] {
    ST_IDLE,     // Waiting for start
    ST_LOAD,     // Taking operands A then B
    ST_COMPUTE,  // Pipeline running
    ST_DONE      // Results waiting in drain
  } eng_state_t;

  // Status word seen by the host on a CTRL read
  typedef struct packed {
    logic                         idle;
    logic                         ready;
    logic                         done;
    logic [`VADD_COUNT_WIDTH-1:0] results_left;
  } vadd_status_t;

endpackage

// File: logic/vadd_bus_pkg.sv
`include "vadd_macros.svh"

package vadd_bus_pkg;

  import vadd_core_pkg::*;

  localparam int STAT_BITS = $bits(vadd_status_t);

  // Master-driven side of the Wishbone port
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`VADD_WB_WIDTH-1:0] adr;
    logic [`VADD_WB_WIDTH-1:0] dat_w;
  } wb_req_t;

  // Slave-driven side
  typedef struct packed {
    logic                      ack;
    logic [`VADD_WB_WIDTH-1:0] dat_r;
  } wb_rsp_t;

  typedef struct packed {
    logic [`VADD_WB_WIDTH-`VADD_DATA_WIDTH-1:0] pad;
    elem_t                                      elem;
  } wb_elem_view_t;

  typedef struct packed {
    logic [`VADD_WB_WIDTH-2:0] pad;
    logic                      start;
  } wb_ctrl_view_t;

  typedef struct packed {
    logic [`VADD_WB_WIDTH-STAT_BITS-1:0] pad;
    vadd_status_t                        status;
  } wb_stat_view_t;

  // Meaning of a bus word depends on the address it travels to
  typedef union packed {
    wb_elem_view_t elem_v;  // Operand writes, result reads
    wb_ctrl_view_t ctrl_v;  // Control writes
    wb_stat_view_t stat_v;  // Status reads
  } wb_word_u;

endpackage

// File: logic/sync_fifo.sv
`timescale 1ns/1ps
`include "vadd_macros.svh"

module sync_fifo
  import vadd_core_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         push,
  input  logic                         pop,
  input  elem_t                        din,
  output elem_t                        dout,
  output logic [`VADD_COUNT_WIDTH-1:0] count,
  output logic                         full,
  output logic                         empty
);

  localparam int DEPTH = `VADD_VECTOR_LENGTH;
  localparam int PTR_W = $clog2(DEPTH);

  elem_t                        mem [DEPTH];
  logic [PTR_W-1:0]             wr_ptr_q;
  logic [PTR_W-1:0]             rd_ptr_q;
  logic [`VADD_COUNT_WIDTH-1:0] count_q;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // Wraps for any depth
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr_q] <= din;
  end

  assign dout  = mem[rd_ptr_q];  // First word falls through
  assign count = count_q;
  assign full  = (count_q == `VADD_COUNT_WIDTH'(DEPTH));
  assign empty = (count_q == '0);

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("sync_fifo: push while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $error("sync_fifo: pop while empty");

endmodule

// File: logic/vadd_wb_slave.sv
`timescale 1ns/1ps
`include "vadd_macros.svh"

module vadd_wb_slave
  import vadd_core_pkg::*;
  import vadd_bus_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  wb_req_t      wb_req,
  output wb_rsp_t      wb_rsp,
  input  vadd_status_t status,
  input  elem_t        result_elem,
  output logic         start_cmd,
  output logic         operand_push,
  output elem_t        operand_data,
  output logic         result_pop
);

  logic       ack_q;
  logic       req_new;
  logic       we_q;
  logic [1:0] adr_q;
  wb_word_u   wr_word_q;
  wb_word_u   rd_word;

  assign req_new = wb_req.cyc && wb_req.stb && !ack_q;  // One ack per strobe

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_new;
    end
  end

  // The master may drop its request halfway through the ack cycle,
  // so the fields used during that cycle are kept here
  always_ff @(posedge clk) begin
    if (req_new) begin
      we_q      <= wb_req.we;
      adr_q     <= wb_req.adr[3:2];  // Word address
      wr_word_q <= wb_req.dat_w;
    end
  end

  assign start_cmd    = ack_q && we_q && (adr_q == `VADD_ADR_CTRL) && wr_word_q.ctrl_v.start;
  assign operand_push = ack_q && we_q && (adr_q == `VADD_ADR_OPERAND);
  assign operand_data = wr_word_q.elem_v.elem;
  assign result_pop   = ack_q && !we_q && (adr_q == `VADD_ADR_RESULT);  // Pops in ack cycle

  always_comb begin
    rd_word = '0;
    if (!we_q) begin
      case (adr_q)
        `VADD_ADR_CTRL:   rd_word.stat_v.status = status;
        `VADD_ADR_RESULT: rd_word.elem_v.elem = result_elem;  // Drain gives 0 when empty
        default:          rd_word = '0;  // OPERAND and unmapped read as 0
      endcase
    end
  end

  assign wb_rsp.ack   = ack_q;
  assign wb_rsp.dat_r = ack_q ? rd_word : '0;

  // Ack answers the strobe of the cycle before and ends the access
  a_ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_q) |-> $past(wb_req.cyc && wb_req.stb) && !wb_req.stb)
    else $error("vadd_wb_slave: ack without strobe, or strobe held past ack");

endmodule

// File: logic/vadd_operand_loader.sv
`timescale 1ns/1ps

module vadd_operand_loader
  import vadd_core_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  load_en,
  input  logic  operand_push,
  input  elem_t operand_data,
  input  logic  operand_pop,
  output elem_t a_data,
  output elem_t b_data,
  output logic  operands_full,
  output logic  operands_empty
);

  logic accept;
  logic push_a;
  logic push_b;
  logic a_full;
  logic b_full;
  logic a_empty;
  logic b_empty;

  assign accept = load_en && operand_push;        // Pushes outside ST_LOAD dropped
  assign push_a = accept && !a_full;
  assign push_b = accept && a_full && !b_full;  // B only once A holds a vector

  sync_fifo fifo_a_i (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (push_a),
    .pop   (operand_pop),
    .din   (operand_data),
    .dout  (a_data),
    .count (),
    .full  (a_full),
    .empty (a_empty)
  );

  sync_fifo fifo_b_i (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (push_b),
    .pop   (operand_pop),
    .din   (operand_data),
    .dout  (b_data),
    .count (),
    .full  (b_full),
    .empty (b_empty)
  );

  assign operands_full  = b_full;
  assign operands_empty = a_empty && b_empty;

endmodule

// File: logic/vadd_engine.sv
`timescale 1ns/1ps

module vadd_engine
  import vadd_core_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start_cmd,
  input  logic  operands_full,
  input  logic  operands_empty,
  input  elem_t a_data,
  input  elem_t b_data,
  input  logic  results_empty,
  output logic  operand_pop,
  output logic  load_en,
  output logic  result_push,
  output elem_t result_data,
  output logic  idle,
  output logic  ready,
  output logic  done
);

  eng_state_t state_q;
  eng_state_t state_d;
  logic       s1_valid_q;
  elem_t      s1_a_q;
  elem_t      s1_b_q;
  logic       s2_valid_q;
  elem_t      s2_sum_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (start_cmd) state_d = ST_LOAD;
      ST_LOAD:    if (operands_full) state_d = ST_COMPUTE;
      ST_COMPUTE: if (operands_empty && !s1_valid_q && !s2_valid_q) state_d = ST_DONE;
      ST_DONE:    if (results_empty) state_d = ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  assign operand_pop = (state_q == ST_COMPUTE) && !operands_empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      s1_valid_q <= operand_pop;
      s2_valid_q <= s1_valid_q;
    end
  end

  // Stage payloads, qualified by the valid bits above
  always_ff @(posedge clk) begin
    if (operand_pop) begin
      s1_a_q <= a_data;
      s1_b_q <= b_data;
    end
    if (s1_valid_q) s2_sum_q <= s1_a_q + s1_b_q;  // Carry dropped, mod 2^16
  end

  assign result_push = s2_valid_q;
  assign result_data = s2_sum_q;
  assign load_en     = (state_q == ST_LOAD);
  assign idle        = (state_q == ST_IDLE);
  assign ready       = (state_q == ST_LOAD);
  assign done        = (state_q == ST_DONE);

  // Operands leave the FIFOs only while computing
  a_pop_in_compute: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != ST_COMPUTE) && !operands_empty |=> !operands_empty)
    else $error("vadd_engine: operand FIFOs popped outside compute");

endmodule

// File: logic/vadd_result_drain.sv
`timescale 1ns/1ps
`include "vadd_macros.svh"

module vadd_result_drain
  import vadd_core_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         result_push,
  input  elem_t                        result_data,
  input  logic                         result_pop,
  output elem_t                        result_elem,
  output logic [`VADD_COUNT_WIDTH-1:0] results_left,
  output logic                         results_empty
);

  logic  pop_ok;
  logic  full;
  elem_t head;

  assign pop_ok = result_pop && !results_empty;  // Read of an empty FIFO is a no-op

  sync_fifo fifo_r_i (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (result_push),
    .pop   (pop_ok),
    .din   (result_data),
    .dout  (head),
    .count (results_left),
    .full  (full),
    .empty (results_empty)
  );

  assign result_elem = results_empty ? '0 : head;

  // FIFO holds a whole vector, so the engine never has to wait
  a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    result_push |-> !full)
    else $error("vadd_result_drain: result pushed into full FIFO");

endmodule

// File: logic/vadd_top.sv
`timescale 1ns/1ps

module vadd_top
  import vadd_core_pkg::*;
  import vadd_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  logic         start_cmd;
  logic         operand_push;
  elem_t        operand_data;
  logic         result_pop;
  logic         load_en;
  elem_t        a_data;
  elem_t        b_data;
  logic         operands_full;
  logic         operands_empty;
  logic         operand_pop;
  logic         result_push;
  elem_t        result_data;
  elem_t        result_data_out;
  logic         results_empty;
  logic         eng_idle;
  logic         eng_ready;
  logic         eng_done;
  vadd_status_t status;

  logic [$bits(status.results_left)-1:0] status_left;  // From the drain

  assign status = '{idle: eng_idle, ready: eng_ready, done: eng_done,
                    results_left: status_left};

  vadd_wb_slave slave_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .status       (status),
    .result_elem  (result_data_out),
    .start_cmd    (start_cmd),
    .operand_push (operand_push),
    .operand_data (operand_data),
    .result_pop   (result_pop)
  );

  vadd_operand_loader loader_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_en        (load_en),
    .operand_push   (operand_push),
    .operand_data   (operand_data),
    .operand_pop    (operand_pop),
    .a_data         (a_data),
    .b_data         (b_data),
    .operands_full  (operands_full),
    .operands_empty (operands_empty)
  );

  vadd_engine engine_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_cmd      (start_cmd),
    .operands_full  (operands_full),
    .operands_empty (operands_empty),
    .a_data         (a_data),
    .b_data         (b_data),
    .results_empty  (results_empty),
    .operand_pop    (operand_pop),
    .load_en        (load_en),
    .result_push    (result_push),
    .result_data    (result_data),
    .idle           (eng_idle),
    .ready          (eng_ready),
    .done           (eng_done)
  );

  vadd_result_drain drain_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .result_push   (result_push),
    .result_data   (result_data),
    .result_pop    (result_pop),
    .result_elem   (result_data_out),
    .results_left  (status_left),
    .results_empty (results_empty)
  );

endmodule

// File: bench/tb_vadd.sv
`timescale 1ns/1ps
`include "vadd_macros.svh"

module tb_vadd
  import vadd_core_pkg::*;
  import vadd_bus_pkg::*;
();

  localparam int LEN             = `VADD_VECTOR_LENGTH;
  localparam int NUM_JOBS        = 5;
  localparam int IDLE_WRITE_JOB  = 2;   // Job preceded by writes while idle
  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 4;
  localparam int ACK_LIMIT       = 16;
  localparam int POLL_LIMIT      = 64;
  localparam int WATCHDOG_CYCLES = NUM_JOBS * (3 * LEN + 4) * 2 * 4 + RESET_CYCLES;
  localparam logic [31:0] SEED   = 32'h4223;

  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;

  int          value_errors;
  int          other_errors;
  int          checks_done;
  elem_t       vec_a [LEN];
  elem_t       vec_b [LEN];
  elem_t       exp_q [$];          // Expected sums, in read order
  elem_t       got_q [$];          // Sums read back from the DUT

  vadd_top dut_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // Element sum with the carry out dropped
  function automatic elem_t ref_add(input elem_t a, input elem_t b);
    logic [`VADD_DATA_WIDTH:0] full_sum;
    full_sum = {1'b0, a} + {1'b0, b};
    return full_sum[`VADD_DATA_WIDTH-1:0];
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks_done++;
    if (got !== exp) begin
      value_errors++;
      $display("ERR %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // Compares result reads against the reference, away from the driving edge
  initial begin
    forever begin
      @(posedge clk);
      while (got_q.size() > 0 && exp_q.size() > 0) begin
        check(32'(got_q.pop_front()), 32'(exp_q.pop_front()), "result element");
      end
    end
  end

  // Starts and ends on a falling edge, two cycles per access
  task automatic bus_access(input logic we, input logic [1:0] word_adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited       = 0;
    rdata        = '0;
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = we;
    wb_req.adr   = {28'd0, word_adr, 2'b00};
    wb_req.dat_w = wdata;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_rsp.ack && waited < ACK_LIMIT);
    if (!wb_rsp.ack) begin
      other_errors++;
      $display("Bus access to word %0d got no ack within %0d cycles", word_adr, ACK_LIMIT);
    end else begin
      check(32'(waited), 32'd1, "ack delay in cycles");
      rdata = wb_rsp.dat_r;
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    @(negedge clk);
    check(32'(wb_rsp.ack), 32'd0, "ack still high after one cycle");
  endtask

  task automatic wb_write(input logic [1:0] word_adr, input logic [31:0] wdata);
    logic [31:0] unused_rd;
    bus_access(1'b1, word_adr, wdata, unused_rd);
  endtask

  task automatic wb_read(input logic [1:0] word_adr, output logic [31:0] rdata);
    bus_access(1'b0, word_adr, '0, rdata);
  endtask

  // Status word: idle, ready, done, then results_left in the low bits
  task automatic expect_status(input logic idle_e, input logic ready_e, input logic done_e,
                               input int left_e, input string what);
    logic [31:0] rd;
    logic [31:0] exp;
    wb_read(`VADD_ADR_CTRL, rd);
    exp = {{(32 - `VADD_COUNT_WIDTH - 3){1'b0}}, idle_e, ready_e, done_e,
           left_e[`VADD_COUNT_WIDTH-1:0]};
    check(rd, exp, what);
  endtask

  task automatic write_while_idle();
    for (int i = 0; i < LEN; i++) begin
      wb_write(`VADD_ADR_OPERAND, 32'hA500 + 32'(i));  // Must not reach the FIFOs
    end
    expect_status(1'b1, 1'b0, 1'b0, 0, "status after operand writes while idle");
  endtask

  task automatic run_job(input int job);
    logic [31:0]  rd;
    vadd_status_t st;
    int           polls;
    for (int i = 0; i < LEN; i++) begin
      if (job == 0) begin
        vec_a[i] = 16'hFFF8 + 16'(i);      // Every sum wraps
        vec_b[i] = 16'h0010 + 16'(3 * i);
      end else begin
        vec_a[i] = elem_t'($urandom());
        vec_b[i] = elem_t'($urandom());
      end
    end
    wb_write(`VADD_ADR_CTRL, 32'h1);
    expect_status(1'b0, 1'b1, 1'b0, 0, "status while loading");
    for (int i = 0; i < LEN; i++) begin
      wb_write(`VADD_ADR_OPERAND, 32'(vec_a[i]));
    end
    for (int i = 0; i < LEN; i++) begin
      wb_write(`VADD_ADR_OPERAND, 32'(vec_b[i]));
    end
    for (int i = 0; i < LEN; i++) begin
      exp_q.push_back(ref_add(vec_a[i], vec_b[i]));
    end
    polls = 0;
    do begin
      wb_read(`VADD_ADR_CTRL, rd);
      st = vadd_status_t'(rd[$bits(vadd_status_t)-1:0]);
      polls++;
    end while (!st.done && polls < POLL_LIMIT);
    if (!st.done) begin
      other_errors++;
      $display("Job %0d never reached done after %0d status polls", job, polls);
    end
    check(32'(st.results_left), 32'(LEN), "results left at done");
    for (int i = 0; i < LEN; i++) begin
      wb_read(`VADD_ADR_RESULT, rd);
      got_q.push_back(rd[`VADD_DATA_WIDTH-1:0]);
      check(32'(rd[31:`VADD_DATA_WIDTH]), 32'd0, "result padding");
      if (i < LEN - 1) begin
        expect_status(1'b0, 1'b0, 1'b1, LEN - 1 - i, "status after result read");
      end
    end
  endtask

  task automatic check_idle_reads();
    logic [31:0] rd;
    expect_status(1'b1, 1'b0, 1'b0, 0, "status back to idle");
    wb_read(`VADD_ADR_RESULT, rd);
    check(rd, 32'd0, "result read with FIFO empty");
    wb_read(`VADD_ADR_OPERAND, rd);
    check(rd, 32'd0, "operand read");
    expect_status(1'b1, 1'b0, 1'b0, 0, "status after reads while idle");
  endtask

  initial begin
    void'($urandom(SEED));
    value_errors = 0;
    other_errors = 0;
    checks_done  = 0;
    rst_n        = 1'b0;
    wb_req       = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check(32'(wb_rsp.ack), 32'd0, "ack after reset");
    expect_status(1'b1, 1'b0, 1'b0, 0, "status after reset");

    for (int job = 0; job < NUM_JOBS; job++) begin
      if (job == IDLE_WRITE_JOB) begin
        write_while_idle();
      end
      run_job(job);
      check_idle_reads();
    end

    repeat (2) @(negedge clk);  // Compare process catches up
    if (exp_q.size() != 0 || got_q.size() != 0) begin
      other_errors++;
      $display("Results left uncompared: %0d expected, %0d read", exp_q.size(), got_q.size());
    end
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks_done, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+logic
logic/vadd_core_pkg.sv
logic/vadd_bus_pkg.sv
logic/sync_fifo.sv
logic/vadd_wb_slave.sv
logic/vadd_operand_loader.sv
logic/vadd_engine.sv
logic/vadd_result_drain.sv
logic/vadd_top.sv
bench/tb_vadd.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the vector-add testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_vadd --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_vadd" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
  echo "Result: pass"
  exit 0
fi

echo "Result: fail"
exit 1
